// ==== ahb_bridge.f ====
+incdir+include
design/ahb_bridge_pkg.sv
design/gen_bus_arbiter.sv
design/ahb_master.sv
design/ahb_sram_slave.sv
design/ahb_bridge_top.sv
sim/tb_ahb_bridge.sv

// ==== design/ahb_bridge_pkg.sv ====
// AHB bridge shared types

`include "ahb_bridge_macros.svh"

package ahb_bridge_pkg;

  // Request from a generic bus requester.
  // The address is word aligned; byte_en picks the lanes.
  typedef struct packed {
    logic                   ren;
    logic                   wen;
    logic [`AHB_ADDR_W-1:0] addr;
    logic [`AHB_DATA_W-1:0] wdata;
    logic [3:0]             byte_en;
  } gen_bus_req_t;

  // Response to a generic bus requester.
  // Busy low marks the single cycle in which a transfer completes.
  typedef struct packed {
    logic                   busy;
    logic [`AHB_DATA_W-1:0] rdata;
    logic                   error;
  } gen_bus_rsp_t;

  // AHB-Lite transfer types; only single transfers are used.
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    NONSEQ = 2'b10
  } htrans_t;

  // AHB-Lite transfer sizes up to the bus width.
  typedef enum logic [2:0] {
    BYTE = 3'b000,
    HALF = 3'b001,
    WORD = 3'b010
  } hsize_t;

  // Signals driven by the AHB-Lite master.
  typedef struct packed {
    htrans_t                htrans;
    logic                   hwrite;
    logic [`AHB_ADDR_W-1:0] haddr;
    hsize_t                 hsize;
    logic [`AHB_DATA_W-1:0] hwdata;
  } ahb_req_t;

  // Signals driven by the AHB-Lite slave.
  typedef struct packed {
    logic                   hready;
    logic                   hresp;
    logic [`AHB_DATA_W-1:0] hrdata;
  } ahb_rsp_t;

  typedef enum logic {
    M_IDLE,
    M_DATA
  } master_state_t;

  typedef enum logic [1:0] {
    S_IDLE,
    S_WAIT,
    S_ERR1,
    S_ERR2
  } slave_state_t;

  typedef enum logic [1:0] {
    OWN_NONE,
    OWN_IPORT,
    OWN_DPORT
  } owner_t;

endpackage

// ==== design/ahb_bridge_top.sv ====
// AHB bridge subsystem top

`include "ahb_bridge_macros.svh"

module ahb_bridge_top (
  input  logic                         CLK,
  input  logic                         nRST,
  input  ahb_bridge_pkg::gen_bus_req_t iport_req,
  output ahb_bridge_pkg::gen_bus_rsp_t iport_rsp,
  input  ahb_bridge_pkg::gen_bus_req_t dport_req,
  output ahb_bridge_pkg::gen_bus_rsp_t dport_rsp
);

  // Merged generic bus between the arbiter and the master.
  ahb_bridge_pkg::gen_bus_req_t m_req;
  ahb_bridge_pkg::gen_bus_rsp_t m_rsp;

  // AHB-Lite bus between the master and the SRAM.
  ahb_bridge_pkg::ahb_req_t ahb_req;
  ahb_bridge_pkg::ahb_rsp_t ahb_rsp;

  gen_bus_arbiter u_arbiter (
    .CLK       (CLK),
    .nRST      (nRST),
    .iport_req (iport_req),
    .iport_rsp (iport_rsp),
    .dport_req (dport_req),
    .dport_rsp (dport_rsp),
    .m_req     (m_req),
    .m_rsp     (m_rsp)
  );

  ahb_master u_master (
    .CLK     (CLK),
    .nRST    (nRST),
    .gen_req (m_req),
    .gen_rsp (m_rsp),
    .ahb_req (ahb_req),
    .ahb_rsp (ahb_rsp)
  );

  ahb_sram_slave #(
    .WAIT_STATES (`SRAM_WAIT_STATES),
    .DEPTH_WORDS (`SRAM_DEPTH_WORDS)
  ) u_sram (
    .CLK     (CLK),
    .nRST    (nRST),
    .ahb_req (ahb_req),
    .ahb_rsp (ahb_rsp)
  );

endmodule

// ==== design/ahb_master.sv ====
// AHB-Lite master for a generic bus

`include "ahb_bridge_macros.svh"

module ahb_master (
  input  logic                         CLK,
  input  logic                         nRST,
  input  ahb_bridge_pkg::gen_bus_req_t gen_req,
  output ahb_bridge_pkg::gen_bus_rsp_t gen_rsp,
  output ahb_bridge_pkg::ahb_req_t     ahb_req,
  input  ahb_bridge_pkg::ahb_rsp_t     ahb_rsp
);

  ahb_bridge_pkg::master_state_t state;
  ahb_bridge_pkg::master_state_t n_state;
  ahb_bridge_pkg::hsize_t        size;

  logic                   req_present;
  logic                   issue;
  logic [1:0]             lane_off;
  logic                   dp_write;
  logic [`AHB_DATA_W-1:0] dp_wdata;

  assign req_present = gen_req.ren | gen_req.wen;

  // An address phase goes out when idle, or when the current data phase
  // completes in this cycle.
  assign issue = req_present && ((state == ahb_bridge_pkg::M_IDLE) || ahb_rsp.hready);

  //////////////////////////////////////////////////////////////////////
  // Transfer state
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    if (issue)
      n_state = ahb_bridge_pkg::M_DATA;
    else if ((state == ahb_bridge_pkg::M_DATA) && !ahb_rsp.hready)
      n_state = ahb_bridge_pkg::M_DATA;
    else
      n_state = ahb_bridge_pkg::M_IDLE;
  end

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      state    <= ahb_bridge_pkg::M_IDLE;
      dp_write <= 1'b0;
    end
    else
    begin
      state <= n_state;
      if (issue)
        dp_write <= gen_req.wen;
    end
  end

  // Write data is captured at the address phase.
  // The arbiter may already present the next port in the completing cycle.
  always_ff @(posedge CLK)
  begin
    if (issue)
      dp_wdata <= gen_req.wdata;
  end

  //////////////////////////////////////////////////////////////////////
  // Size and byte address
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    if (gen_req.byte_en == 4'b1111)
      size = ahb_bridge_pkg::WORD;
    else if ((gen_req.byte_en == 4'b1100) || (gen_req.byte_en == 4'b0011))
      size = ahb_bridge_pkg::HALF;
    else
      size = ahb_bridge_pkg::BYTE;
  end

  // Offset of the lowest enabled lane inside the word.
  always_comb
  begin
    if (gen_req.byte_en[0])
      lane_off = 2'd0;
    else if (gen_req.byte_en[1])
      lane_off = 2'd1;
    else if (gen_req.byte_en[2])
      lane_off = 2'd2;
    else
      lane_off = 2'd3;
  end

  always_comb
  begin
    ahb_req.htrans = issue ? ahb_bridge_pkg::NONSEQ : ahb_bridge_pkg::IDLE;
    ahb_req.hwrite = issue && gen_req.wen;
    ahb_req.haddr  = issue ? {gen_req.addr[`AHB_ADDR_W-1:2], lane_off} : '0;
    ahb_req.hsize  = size;
    ahb_req.hwdata = dp_wdata;
  end

  // Busy drops only in the cycle that ends the data phase.
  // Error is taken from the second ERROR cycle, the one with hready high.
  assign gen_rsp.busy  = !((state == ahb_bridge_pkg::M_DATA) && ahb_rsp.hready);
  assign gen_rsp.error = (state == ahb_bridge_pkg::M_DATA) && ahb_rsp.hready && ahb_rsp.hresp;
  assign gen_rsp.rdata = dp_write ? '0 : ahb_rsp.hrdata;

  a_one_dir: assert property (
    @(posedge CLK) disable iff (!nRST)
    !(gen_req.ren && gen_req.wen)
  ) else $error("read and write requested together");

  a_byte_en: assert property (
    @(posedge CLK) disable iff (!nRST)
    req_present |-> ((gen_req.byte_en == 4'b1111) || (gen_req.byte_en == 4'b1100) ||
                     (gen_req.byte_en == 4'b0011) || $onehot(gen_req.byte_en))
  ) else $error("illegal byte enable pattern");

  // The requester holds its request through every wait cycle.
  a_req_stable: assert property (
    @(posedge CLK) disable iff (!nRST)
    ((state == ahb_bridge_pkg::M_DATA) && gen_rsp.busy) |-> $stable(gen_req)
  ) else $error("request changed while the transfer was busy");

endmodule

// ==== design/ahb_sram_slave.sv ====
// AHB-Lite SRAM slave

`include "ahb_bridge_macros.svh"

module ahb_sram_slave #(
  parameter int WAIT_STATES = `SRAM_WAIT_STATES,
  parameter int DEPTH_WORDS = `SRAM_DEPTH_WORDS
) (
  input  logic                     CLK,
  input  logic                     nRST,
  input  ahb_bridge_pkg::ahb_req_t ahb_req,
  output ahb_bridge_pkg::ahb_rsp_t ahb_rsp
);

  localparam int IDX_W = $clog2(DEPTH_WORDS);
  localparam int CNT_W = (WAIT_STATES > 1) ? $clog2(WAIT_STATES) : 1;
  localparam logic [`AHB_ADDR_W-1:0] ADDR_LIMIT = DEPTH_WORDS * 4;

  ahb_bridge_pkg::slave_state_t state;
  ahb_bridge_pkg::slave_state_t n_state;
  ahb_bridge_pkg::hsize_t       size_q;

  logic [CNT_W-1:0]       wait_cnt;
  logic [CNT_W-1:0]       n_wait_cnt;
  logic                   hready;
  logic                   addr_phase;
  logic                   out_of_range;
  logic                   dphase;
  logic                   err_q;
  logic                   done;
  logic [`AHB_ADDR_W-1:0] addr_q;
  logic                   write_q;
  logic [IDX_W-1:0]       word_idx;
  logic [3:0]             lane_en;
  logic [`AHB_DATA_W-1:0] mem [DEPTH_WORDS];

  // Hready is high except while waiting or in the first ERROR cycle.
  assign hready = (state == ahb_bridge_pkg::S_IDLE) || (state == ahb_bridge_pkg::S_ERR2);

  assign addr_phase   = hready && (ahb_req.htrans == ahb_bridge_pkg::NONSEQ);
  assign out_of_range = (ahb_req.haddr >= ADDR_LIMIT);

  // A good data phase ends in the first cycle with hready high.
  assign done = dphase && hready && !err_q;

  //////////////////////////////////////////////////////////////////////
  // Response sequencing
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    n_state    = state;
    n_wait_cnt = wait_cnt;
    case (state)
      ahb_bridge_pkg::S_IDLE, ahb_bridge_pkg::S_ERR2:
      begin
        n_state = ahb_bridge_pkg::S_IDLE;
        if (addr_phase)
        begin
          // A bad address spends one decode cycle in S_WAIT whatever
          // the wait count, then gives the two ERROR cycles.
          if (out_of_range)
            n_state = ahb_bridge_pkg::S_WAIT;
          else if (WAIT_STATES > 0)
          begin
            n_state    = ahb_bridge_pkg::S_WAIT;
            n_wait_cnt = CNT_W'(WAIT_STATES - 1);
          end
        end
      end
      ahb_bridge_pkg::S_WAIT:
      begin
        if (err_q)
          n_state = ahb_bridge_pkg::S_ERR1;
        else if (wait_cnt == '0)
          n_state = ahb_bridge_pkg::S_IDLE;
        else
          n_wait_cnt = wait_cnt - 1'b1;
      end
      ahb_bridge_pkg::S_ERR1:
        n_state = ahb_bridge_pkg::S_ERR2;
      default:
        n_state = ahb_bridge_pkg::S_IDLE;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      state    <= ahb_bridge_pkg::S_IDLE;
      wait_cnt <= '0;
      dphase   <= 1'b0;
      err_q    <= 1'b0;
    end
    else
    begin
      state    <= n_state;
      wait_cnt <= n_wait_cnt;
      // Every edge with hready high closes one data phase and may open the next.
      if (hready)
      begin
        dphase <= addr_phase;
        err_q  <= addr_phase && out_of_range;
      end
    end
  end

  always_ff @(posedge CLK)
  begin
    if (addr_phase)
    begin
      addr_q  <= ahb_req.haddr;
      write_q <= ahb_req.hwrite;
      size_q  <= ahb_req.hsize;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Memory array
  //////////////////////////////////////////////////////////////////////

  assign word_idx = addr_q[IDX_W+1:2];

  always_comb
  begin
    case (size_q)
      ahb_bridge_pkg::WORD: lane_en = 4'b1111;
      ahb_bridge_pkg::HALF: lane_en = addr_q[1] ? 4'b1100 : 4'b0011;
      default:              lane_en = 4'b0001 << addr_q[1:0];
    endcase
  end

  // Writes land at the end of the last data cycle on the enabled lanes only.
  always_ff @(posedge CLK)
  begin
    if (done && write_q)
    begin
      for (int i = 0; i < 4; i++)
      begin
        if (lane_en[i])
          mem[word_idx][8*i +: 8] <= ahb_req.hwdata[8*i +: 8];
      end
    end
  end

  assign ahb_rsp.hready = hready;
  assign ahb_rsp.hresp  = (state == ahb_bridge_pkg::S_ERR1) || (state == ahb_bridge_pkg::S_ERR2);
  assign ahb_rsp.hrdata = mem[word_idx];

  // The master derives the byte address from the enabled lanes, so sized
  // transfers must arrive naturally aligned.
  a_aligned: assert property (
    @(posedge CLK) disable iff (!nRST)
    addr_phase |-> (((ahb_req.hsize != ahb_bridge_pkg::HALF) || !ahb_req.haddr[0]) &&
                    ((ahb_req.hsize != ahb_bridge_pkg::WORD) || (ahb_req.haddr[1:0] == 2'b00)))
  ) else $error("misaligned AHB address for its size");

endmodule

// ==== design/gen_bus_arbiter.sv ====
// Fixed-priority generic bus arbiter

module gen_bus_arbiter (
  input  logic                         CLK,
  input  logic                         nRST,
  input  ahb_bridge_pkg::gen_bus_req_t iport_req,
  output ahb_bridge_pkg::gen_bus_rsp_t iport_rsp,
  input  ahb_bridge_pkg::gen_bus_req_t dport_req,
  output ahb_bridge_pkg::gen_bus_rsp_t dport_rsp,
  output ahb_bridge_pkg::gen_bus_req_t m_req,
  input  ahb_bridge_pkg::gen_bus_rsp_t m_rsp
);

  // The owner is the port whose transfer is in its data phase.
  // It is set in the address phase cycle and cleared or handed over
  // in the cycle where the master reports completion.
  ahb_bridge_pkg::owner_t owner;
  ahb_bridge_pkg::owner_t next_owner;

  logic iport_active;
  logic dport_active;
  logic handoff;

  assign iport_active = iport_req.ren | iport_req.wen;
  assign dport_active = dport_req.ren | dport_req.wen;

  //////////////////////////////////////////////////////////////////////
  // Grant selection
  //////////////////////////////////////////////////////////////////////

  // A new address phase can go out when nothing is in flight, or in
  // the completing cycle of the current data phase.
  assign handoff = (owner == ahb_bridge_pkg::OWN_NONE) || !m_rsp.busy;

  always_comb
  begin
    next_owner = owner;
    if (handoff)
    begin
      // The data port has priority.
      // A port that is completing now still shows its old request, so it
      // is skipped and may compete again from the next cycle.
      if (dport_active && (owner != ahb_bridge_pkg::OWN_DPORT))
        next_owner = ahb_bridge_pkg::OWN_DPORT;
      else if (iport_active && (owner != ahb_bridge_pkg::OWN_IPORT))
        next_owner = ahb_bridge_pkg::OWN_IPORT;
      else
        next_owner = ahb_bridge_pkg::OWN_NONE;
    end
  end

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
      owner <= ahb_bridge_pkg::OWN_NONE;
    else
      owner <= next_owner;
  end

  // The request follows the new grant at once, which lets the address
  // phase go out in the same cycle the request is raised.
  always_comb
  begin
    case (next_owner)
      ahb_bridge_pkg::OWN_DPORT: m_req = dport_req;
      ahb_bridge_pkg::OWN_IPORT: m_req = iport_req;
      default:                   m_req = '0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Response routing
  //////////////////////////////////////////////////////////////////////

  // Only the owner sees the master's busy and error.
  // The other port is held busy so it never takes someone else's data.
  always_comb
  begin
    iport_rsp.rdata = m_rsp.rdata;
    dport_rsp.rdata = m_rsp.rdata;
    iport_rsp.busy  = (owner == ahb_bridge_pkg::OWN_IPORT) ? m_rsp.busy : 1'b1;
    dport_rsp.busy  = (owner == ahb_bridge_pkg::OWN_DPORT) ? m_rsp.busy : 1'b1;
    iport_rsp.error = (owner == ahb_bridge_pkg::OWN_IPORT) && m_rsp.error;
    dport_rsp.error = (owner == ahb_bridge_pkg::OWN_DPORT) && m_rsp.error;
  end

  // Every completion from the master must land on the port holding the grant.
  a_owner_locked: assert property (
    @(posedge CLK) disable iff (!nRST)
    !m_rsp.busy |-> (owner != ahb_bridge_pkg::OWN_NONE)
  ) else $error("master completed a transfer with no port granted");

endmodule

// ==== include/ahb_bridge_macros.svh ====
// AHB bridge build constants

`ifndef AHB_BRIDGE_MACROS_SVH
`define AHB_BRIDGE_MACROS_SVH

// Width of HADDR and of the generic bus address.
`define AHB_ADDR_W 32

// Width of HWDATA, HRDATA and the generic bus data words.
`define AHB_DATA_W 32

// Number of 32-bit words held by the SRAM slave.
// Byte addresses at or above four times this value are answered with ERROR.
`define SRAM_DEPTH_WORDS 256

// Wait states the SRAM inserts before finishing a good data phase.
`define SRAM_WAIT_STATES 1

`endif

// ==== run_sim.sh ====
#!/bin/sh
# Build the AHB bridge testbench with Verilator, run it and judge the log.

LOG=sim.log

verilator --binary --timing --assert --top-module tb_ahb_bridge \
  -f ahb_bridge.f -o tb_ahb_bridge > "$LOG" 2>&1 &&
  ./obj_dir/tb_ahb_bridge >> "$LOG" 2>&1 ||
  { cat "$LOG"; echo "Build or simulation step did not complete"; exit 1; }

cat "$LOG"
grep -q "Something failed" "$LOG" && { echo "Result: FAIL"; exit 1; } ||
  { echo "Result: PASS"; exit 0; }

// ==== sim/tb_ahb_bridge.sv ====
// AHB bridge testbench

`include "ahb_bridge_macros.svh"

module tb_ahb_bridge;

  localparam int MEM_BYTES = `SRAM_DEPTH_WORDS * 4;
  localparam int BYTE_W    = $clog2(MEM_BYTES);
  localparam int TIMEOUT   = 50;

  logic                         CLK;
  logic                         nRST;
  ahb_bridge_pkg::gen_bus_req_t iport_req;
  ahb_bridge_pkg::gen_bus_rsp_t iport_rsp;
  ahb_bridge_pkg::gen_bus_req_t dport_req;
  ahb_bridge_pkg::gen_bus_rsp_t dport_rsp;

  integer     seed = 96673;
  integer     errors = 0;
  integer     transfers = 0;
  logic       timed_out = 1'b0;
  // Byte image of the SRAM that only good writes update.
  logic [7:0] model [MEM_BYTES];
  // Time of the last completion seen by each port.
  // Index 0 is the iport.
  time        done_time [2];

  ahb_bridge_top u_ahb_bridge_top (
    .CLK       (CLK),
    .nRST      (nRST),
    .iport_req (iport_req),
    .iport_rsp (iport_rsp),
    .dport_req (dport_req),
    .dport_rsp (dport_rsp)
  );

  initial CLK = 1'b0;
  always #10 CLK = ~CLK;

  //////////////////////////////////////////////////////////////////////
  // Port access helpers
  //////////////////////////////////////////////////////////////////////

  function automatic ahb_bridge_pkg::gen_bus_rsp_t rsp_of(input int port);
    if (port == 0)
      return iport_rsp;
    else
      return dport_rsp;
  endfunction

  function automatic string port_name(input int port);
    return (port == 0) ? "iport" : "dport";
  endfunction

  task automatic drive_req(input int port, input ahb_bridge_pkg::gen_bus_req_t req);
    if (port == 0)
      iport_req = req;
    else
      dport_req = req;
  endtask

  // Initial SRAM contents are a hash of the full byte address.
  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return (addr * 32'h9E37_79B1) ^ 32'h5A5A_C3C3;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp)
    else
    begin
      errors++;
      $display("** Error at %0t: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
    end
  endtask

  // An idle port must see busy high and error low on every cycle.
  task automatic idle_cycles(input int port, input int count);
    ahb_bridge_pkg::gen_bus_rsp_t rsp;
    repeat (count)
    begin
      @(negedge CLK);
      rsp = rsp_of(port);
      check_value({port_name(port), ".busy"}, 32'(rsp.busy), 32'd1);
      check_value({port_name(port), ".error"}, 32'(rsp.error), 32'd0);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Transfers
  //////////////////////////////////////////////////////////////////////

  // Presents one request on the falling edge and holds it until busy is
  // seen low. Latency counts falling edges from presentation to completion.
  task automatic run_transfer(input int port, input logic wr, input logic [31:0] addr,
                              input logic [31:0] wdata, input logic [3:0] be,
                              output int latency);
    ahb_bridge_pkg::gen_bus_req_t req;
    ahb_bridge_pkg::gen_bus_rsp_t rsp;
    logic [31:0]       exp_word;
    logic [31:0]       mask;
    logic [BYTE_W-1:0] bidx;
    logic              bad;
    req.ren     = !wr;
    req.wen     = wr;
    req.addr    = addr;
    req.wdata   = wdata;
    req.byte_en = be;
    bad         = (addr >= MEM_BYTES);
    drive_req(port, req);
    latency  = 0;
    rsp.busy = 1'b1;
    while (rsp.busy && (latency < TIMEOUT))
    begin
      @(negedge CLK);
      latency++;
      rsp = rsp_of(port);
    end
    if (rsp.busy)
    begin
      errors++;
      timed_out = 1'b1;
      $display("Timeout: %s never finished its transfer to 0x%08h", port_name(port), addr);
    end
    else
    begin
      transfers++;
      done_time[port] = $time;
      check_value({port_name(port), ".error"}, 32'(rsp.error), 32'(bad));
      if (!bad)
      begin
        for (int i = 0; i < 4; i++)
        begin
          bidx = BYTE_W'(addr) + BYTE_W'(i);
          mask[8*i +: 8] = {8{be[i]}};
          // Only enabled lanes change; other lanes keep the model contents.
          if (wr && be[i])
            model[bidx] = wdata[8*i +: 8];
          exp_word[8*i +: 8] = model[bidx];
        end
        if (!wr)
          check_value({port_name(port), ".rdata"}, rsp.rdata & mask, exp_word & mask);
      end
    end
    drive_req(port, '0);
  endtask

  // Random direction, size and word address; optionally out of range.
  task automatic pick_request(input logic allow_bad, output logic wr, output logic [31:0] addr,
                              output logic [31:0] wdata, output logic [3:0] be);
    logic [31:0] r;
    int unsigned idx;
    r  = $random(seed);
    wr = r[0];
    case (r[3:1])
      3'd0:    be = 4'b1111;
      3'd1:    be = 4'b0011;
      3'd2:    be = 4'b1100;
      default: be = 4'b0001 << r[5:4];
    endcase
    idx  = 32'(r[31:10]) % `SRAM_DEPTH_WORDS;
    addr = idx << 2;
    if (allow_bad && (r[9:6] == 4'd0))
      addr = addr + MEM_BYTES;
    wdata = $random(seed);
  endtask

  task automatic random_traffic(input int port, input int count);
    logic        wr;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  be;
    int          lat;
    int          gap;
    for (int n = 0; (n < count) && !timed_out; n++)
    begin
      pick_request(1'b1, wr, addr, wdata, be);
      run_transfer(port, wr, addr, wdata, be, lat);
      gap = $random(seed) & 3;
      idle_cycles(port, gap);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    int          lat;
    int          lat_i;
    logic        wr;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  be;
    iport_req = '0;
    dport_req = '0;
    nRST      = 1'b0;

    // Both ports stay quiet through reset and the first idle cycles.
    fork
      idle_cycles(0, 16);
      idle_cycles(1, 16);
    join
    nRST = 1'b1;
    fork
      idle_cycles(0, 3);
      idle_cycles(1, 3);
    join

    // Known contents in every word before any read.
    for (int w = 0; (w < `SRAM_DEPTH_WORDS) && !timed_out; w++)
      run_transfer(1, 1'b1, 32'(w * 4), fill_word(32'(w * 4)), 4'b1111, lat);
    idle_cycles(1, 1);

    // Sized writes followed by word reads of the same word.
    for (int n = 0; (n < 40) && !timed_out; n++)
    begin
      pick_request(1'b0, wr, addr, wdata, be);
      run_transfer(n % 2, 1'b1, addr, wdata, be, lat);
      run_transfer(n % 2, 1'b0, addr, 32'd0, 4'b1111, lat);
      idle_cycles(n % 2, 1);
    end

    // An out-of-range write aliasing word 5 must leave it unchanged.
    run_transfer(1, 1'b1, 32'(MEM_BYTES + 20), 32'hDEAD_BEEF, 4'b1111, lat);
    run_transfer(0, 1'b0, 32'(MEM_BYTES + 24), 32'd0, 4'b1111, lat);
    run_transfer(1, 1'b0, 32'd20, 32'd0, 4'b1111, lat);
    idle_cycles(1, 1);

    // Latency from an idle system with one wait state.
    run_transfer(1, 1'b1, 32'd64, 32'h1234_5678, 4'b1111, lat);
    check_value("dport write latency", 32'(lat), 32'd2);
    idle_cycles(1, 1);
    run_transfer(0, 1'b0, 32'd64, 32'd0, 4'b1111, lat);
    check_value("iport read latency", 32'(lat), 32'd2);
    idle_cycles(0, 1);
    run_transfer(1, 1'b0, 32'(MEM_BYTES + 64), 32'd0, 4'b1111, lat);
    check_value("dport error latency", 32'(lat), 32'd3);
    idle_cycles(1, 1);

    // Same-cycle requests; the data port wins and the iport follows.
    fork
      run_transfer(1, 1'b1, 32'd128, 32'hA5A5_0F0F, 4'b1111, lat);
      run_transfer(0, 1'b1, 32'd132, 32'h3C3C_F0F0, 4'b1111, lat_i);
    join
    // The iport address phase goes out in the cycle the dport completes.
    check_value("dport contended latency", 32'(lat), 32'd2);
    check_value("iport contended latency", 32'(lat_i), 32'd4);
    fork
      run_transfer(1, 1'b0, 32'd132, 32'd0, 4'b1111, lat);
      run_transfer(0, 1'b0, 32'd128, 32'd0, 4'b1111, lat_i);
    join
    assert (done_time[1] < done_time[0])
    else
    begin
      errors++;
      $display("Order problem: the dport did not finish ahead of the iport at %0t", $time);
    end

    // Long mixed run on both ports at once.
    fork
      random_traffic(0, 300);
      random_traffic(1, 300);
    join

    $display("Closing: %0d transfers checked, %0d errors", transfers, errors);
    if (errors == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule
